// ==== build.f ====
design/magnitude_pkg.sv
design/pipe_stage.sv
design/square_sum.sv
design/isqrt_iter.sv
design/magnitude_top.sv
testbench/clock_gen.sv
testbench/magnitude_tb.sv

// ==== design/isqrt_iter.sv ====
`timescale 1ns/1ps

module isqrt_iter (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [magnitude_pkg::SUMSQ_W-1:0] recv_msg,
  input  logic                              recv_val,
  output logic                              recv_rdy,
  output magnitude_pkg::root_t              send_msg,
  output logic                              send_val,
  input  logic                              send_rdy
);
  import magnitude_pkg::*;

  localparam int CNT_W = $clog2(ROOT_W);
  localparam int ACC_W = ROOT_W + 2;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd3
  } state_t;

  state_t state;
  state_t state_next;

  logic [CNT_W-1:0] iter;
  logic             last_iter;
  logic             accept;

  // datapath registers
  logic [RAD_W-1:0] rad;
  logic [ACC_W-1:0] acc;
  root_t            root_q;

  logic [ACC_W-1:0] acc_shift;
  logic [ACC_W-1:0] test_res;
  logic             test_ok;

  // ==========================================================================
  // control
  // ==========================================================================

  assign accept    = recv_val && recv_rdy;
  assign last_iter = (iter == CNT_W'(ROOT_W - 1));

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = CALC;
        end
      end
      CALC: begin
        if (last_iter) begin
          state_next = DONE;
        end
      end
      DONE: begin
        if (send_val && send_rdy) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      iter  <= '0;
    end else begin
      state <= state_next;
      // counts calc cycles only
      if (state == CALC) begin
        iter <= iter + 1'b1;
      end else begin
        iter <= '0;
      end
    end
  end

  assign recv_rdy = (state == IDLE);
  assign send_val = (state == DONE);

  // ==========================================================================
  // datapath
  // ==========================================================================

  // next two radicand bits into the remainder
  assign acc_shift = {acc[ROOT_W-1:0], rad[RAD_W-1 -: 2]};

  // trial subtract of root with 01 appended, msb is the sign
  assign test_res = acc_shift - {root_q, 2'b01};
  assign test_ok  = ~test_res[ACC_W-1];

  always_ff @(posedge clk) begin
    if (accept) begin
      rad    <= RAD_W'(recv_msg);
      acc    <= '0;
      root_q <= '0;
    end else if (state == CALC) begin
      rad <= {rad[RAD_W-3:0], 2'b00};
      if (test_ok) begin
        acc    <= test_res;
        root_q <= {root_q[ROOT_W-2:0], 1'b1};
      end else begin
        // restore
        acc    <= acc_shift;
        root_q <= {root_q[ROOT_W-2:0], 1'b0};
      end
    end
  end

  assign send_msg = root_q;

endmodule

// ==== design/magnitude_pkg.sv ====
package magnitude_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================

  // one coordinate
  localparam int COORD_W = 8;

  // x*x + y*y, largest is 130050
  localparam int SUMSQ_W = 17;

  // radicand padded to an even width, two bits per step
  localparam int RAD_W = SUMSQ_W + (SUMSQ_W % 2);

  // root width, also the iteration count
  localparam int ROOT_W = RAD_W / 2;

  // ==========================================================================
  // payload types
  // ==========================================================================

  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } coord_pair_t;

  typedef logic [ROOT_W-1:0] root_t;

endpackage

// ==== design/magnitude_top.sv ====
`timescale 1ns/1ps

module magnitude_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [magnitude_pkg::COORD_W-1:0] in_x,
  input  logic [magnitude_pkg::COORD_W-1:0] in_y,
  input  logic                              in_val,
  output logic                              in_rdy,
  output magnitude_pkg::root_t              out_mag,
  output logic                              out_val,
  input  logic                              out_rdy
);
  import magnitude_pkg::*;

  coord_pair_t        in_pair;
  coord_pair_t        pair;
  logic               pair_val;
  logic               pair_rdy;
  logic [SUMSQ_W-1:0] sumsq;
  logic               sumsq_val;
  logic               sumsq_rdy;
  root_t              root;
  logic               root_val;
  logic               root_rdy;

  assign in_pair = '{x: in_x, y: in_y};

  // ==========================================================================
  // stage chain
  // ==========================================================================

  pipe_stage #(
    .payload_t(coord_pair_t)
  ) in_stage (
    .clk     (clk),
    .reset   (reset),
    .in_data (in_pair),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .out_data(pair),
    .out_val (pair_val),
    .out_rdy (pair_rdy)
  );

  square_sum squarer (
    .clk    (clk),
    .reset  (reset),
    .in_pair(pair),
    .in_val (pair_val),
    .in_rdy (pair_rdy),
    .sumsq  (sumsq),
    .out_val(sumsq_val),
    .out_rdy(sumsq_rdy)
  );

  isqrt_iter root_unit (
    .clk     (clk),
    .reset   (reset),
    .recv_msg(sumsq),
    .recv_val(sumsq_val),
    .recv_rdy(sumsq_rdy),
    .send_msg(root),
    .send_val(root_val),
    .send_rdy(root_rdy)
  );

  pipe_stage #(
    .payload_t(root_t)
  ) out_stage (
    .clk     (clk),
    .reset   (reset),
    .in_data (root),
    .in_val  (root_val),
    .in_rdy  (root_rdy),
    .out_data(out_mag),
    .out_val (out_val),
    .out_rdy (out_rdy)
  );

endmodule

// ==== design/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_val,
  output logic     in_rdy,
  output payload_t out_data,
  output logic     out_val,
  input  logic     out_rdy
);

  payload_t skid_data;
  logic     skid_val;
  logic     in_fire;
  logic     stall;

  // ready is just the inverted skid flag, so it comes straight from a flop
  assign in_rdy  = ~skid_val;
  assign in_fire = in_val && in_rdy;
  assign stall   = out_val && !out_rdy;

  // occupancy flags
  always_ff @(posedge clk) begin
    if (reset) begin
      out_val  <= 1'b0;
      skid_val <= 1'b0;
    end else if (skid_val) begin
      // main is full here, drain skid into main
      out_val <= 1'b1;
      if (out_rdy) begin
        skid_val <= 1'b0;
      end
    end else if (in_fire) begin
      out_val <= 1'b1;
      if (stall) begin
        skid_val <= 1'b1;
      end
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (skid_val) begin
      if (out_rdy) begin
        out_data <= skid_data;
      end
    end else if (in_fire) begin
      if (stall) begin
        skid_data <= in_data;
      end else begin
        out_data <= in_data;
      end
    end
  end

endmodule

// ==== design/square_sum.sv ====
`timescale 1ns/1ps

module square_sum (
  input  logic                              clk,
  input  logic                              reset,
  input  magnitude_pkg::coord_pair_t        in_pair,
  input  logic                              in_val,
  output logic                              in_rdy,
  output logic [magnitude_pkg::SUMSQ_W-1:0] sumsq,
  output logic                              out_val,
  input  logic                              out_rdy
);
  import magnitude_pkg::*;

  logic [2*COORD_W-1:0] x_sq;
  logic [2*COORD_W-1:0] y_sq;
  logic [SUMSQ_W-1:0]   sum_next;
  logic                 accept;

  // squares and their sum
  assign x_sq     = in_pair.x * in_pair.x;
  assign y_sq     = in_pair.y * in_pair.y;
  assign sum_next = SUMSQ_W'(x_sq) + SUMSQ_W'(y_sq);

  // take a new pair when empty or when the held sum leaves this cycle
  assign in_rdy = ~out_val | out_rdy;
  assign accept = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_val <= 1'b0;
    end else if (accept) begin
      out_val <= 1'b1;
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  // sum is held while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      sumsq <= sum_next;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the magnitude testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f \
  --top-module magnitude_tb -o sim_magnitude
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_magnitude
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // high for the first two rising edges, released just after the second
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// ==== testbench/magnitude_tb.sv ====
`timescale 1ns/1ps

module magnitude_tb;
  import magnitude_pkg::*;

  localparam int MAX_TESTS = 64;

  logic               clk;
  logic               reset;
  logic [COORD_W-1:0] in_x;
  logic [COORD_W-1:0] in_y;
  logic               in_val;
  logic               in_rdy;
  root_t              out_mag;
  logic               out_val;
  logic               out_rdy;

  // test table from the data file
  logic [8*24-1:0]    tnames [MAX_TESTS];
  logic [COORD_W-1:0] tx [MAX_TESTS];
  logic [COORD_W-1:0] ty [MAX_TESTS];
  int                 texp [MAX_TESTS];
  int                 n_tests = 0;
  int                 n_got = 0;
  logic               loaded = 1'b0;
  logic               saw_full = 1'b0;
  integer             seed = 57641;

  clock_gen clk_gen (
    .clk  (clk),
    .reset(reset)
  );

  magnitude_top magnitude_top_inst (
    .clk    (clk),
    .reset  (reset),
    .in_x   (in_x),
    .in_y   (in_y),
    .in_val (in_val),
    .in_rdy (in_rdy),
    .out_mag(out_mag),
    .out_val(out_val),
    .out_rdy(out_rdy)
  );

  task check_value(input logic [8*24-1:0] name, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERR %0s: expected %0d, actual %0d", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task load_tests;
    int              fd;
    int              code;
    int              cnt;
    int              vx;
    int              vy;
    int              ve;
    int              s;
    logic [8*128-1:0] line;
    logic [8*24-1:0]  name;
    fd = $fopen("testbench/magnitude_tests.txt", "r");
    if (fd == 0) begin
      $display("Test failed");
      $fatal(1, "could not open testbench/magnitude_tests.txt");
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      code = $fgets(line, fd);
      // comment lines stop the scan after the first word
      cnt = $sscanf(line, "%s %d %d %d", name, vx, vy, ve);
      if (code > 0 && cnt == 4) begin
        s = vx * vx + vy * vy;
        // expected must be floor(sqrt(x*x + y*y))
        if (ve * ve > s || (ve + 1) * (ve + 1) <= s) begin
          $display("Test failed");
          $fatal(1, "tests file has a wrong expected value for %0s", name);
        end
        tnames[n_tests] = name;
        tx[n_tests]     = vx[COORD_W-1:0];
        ty[n_tests]     = vy[COORD_W-1:0];
        texp[n_tests]   = ve;
        n_tests         = n_tests + 1;
      end
    end
    $fclose(fd);
    if (n_tests == 0) begin
      $display("Test failed");
      $fatal(1, "the tests file holds no tests");
    end
  endtask

  // ==========================================================================
  // driver with random input gaps and output stalls
  // ==========================================================================

  initial begin
    int   idx;
    int   gap;
    logic fire;
    in_x    = '0;
    in_y    = '0;
    in_val  = 1'b0;
    out_rdy = 1'b1;
    idx     = 0;
    gap     = 0;
    load_tests();
    loaded = 1'b1;
    // during reset and one cycle after release
    repeat (3) begin
      @(negedge clk);
      check_value("reset", 0, int'(out_val));
      check_value("reset", 1, int'(in_rdy));
    end
    while (idx < n_tests) begin
      @(negedge clk);
      fire = in_val && in_rdy;
      if (in_val && !in_rdy) begin
        saw_full = 1'b1;
      end
      @(posedge clk);
      #1;
      out_rdy = (($random(seed) & 3) != 0);
      if (fire) begin
        idx    = idx + 1;
        in_val = 1'b0;
        gap    = $random(seed) & 3;
      end
      if (!in_val && idx < n_tests) begin
        if (gap == 0) begin
          in_x   = tx[idx];
          in_y   = ty[idx];
          in_val = 1'b1;
        end else begin
          gap = gap - 1;
        end
      end
    end
    while (n_got < n_tests) begin
      @(posedge clk);
      #1;
      out_rdy = (($random(seed) & 3) != 0);
    end
    // quiet window to catch an extra result
    out_rdy = 1'b1;
    repeat (2 * (ROOT_W + 8)) @(posedge clk);
    if (saw_full) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "in_rdy never fell, so the pipeline never filled up");
    end
  end

  // ==========================================================================
  // monitor and watchdog
  // ==========================================================================

  // sampled at the falling edge before the transfer edge
  initial begin
    logic held;
    int   held_mag;
    held     = 1'b0;
    held_mag = 0;
    forever begin
      @(negedge clk);
      if (held) begin
        check_value(tnames[n_got], 1, int'(out_val));
        check_value(tnames[n_got], held_mag, int'(out_mag));
      end
      if (out_val && out_rdy) begin
        if (n_got >= n_tests) begin
          $display("Test failed");
          $fatal(1, "the DUT returned more results than there are tests");
        end else begin
          check_value(tnames[n_got], texp[n_got], int'(out_mag));
          n_got = n_got + 1;
        end
      end
      held     = out_val && !out_rdy;
      held_mag = int'(out_mag);
    end
  end

  initial begin
    wait (loaded);
    repeat (n_tests * (ROOT_W + 8) * 4) @(posedge clk);
    $display("Test failed");
    $fatal(1, "timeout, results stopped arriving after %0d of %0d", n_got, n_tests);
  end

endmodule

// ==== testbench/magnitude_tests.txt ====
# columns: test name, x, y, expected floor(sqrt(x*x + y*y))
# all values decimal
zero_zero 0 0 0
three_four 3 4 5
max_x 255 0 255
max_both 255 255 360
one_one 1 1 1
ten_ten 10 10 14
zero_seven 0 7 7
five_twelve 5 12 13
eight_fifteen 8 15 17
seven_24 7 24 25
twenty_21 20 21 29
one_zero 1 0 1
two_two 2 2 2
hundred_hundred 100 100 141
x200_y150 200 150 250
x255_y1 255 1 255
x128_y128 128 128 181
x17_y31 17 31 35
x99_y1 99 1 99
x254_y255 254 255 359
x60_y91 60 91 109
three_three 3 3 4
fifty_zero 50 0 50
max_y 0 255 255
x12_y200 12 200 200
x33_y56 33 56 65
six_six 6 6 8
x240_y70 240 70 250
x1_y254 1 254 254
x127_y127 127 127 179
